// ==== tb.f ====
src/motor_pkg.sv
src/cmd_pkg.sv
src/move_if.sv
src/spi_target.sv
src/cmd_fsm.sv
src/step_timer.sv
src/dual_hbridge.sv
src/quad_enc.sv
src/rapcore.sv
verif/tb_rapcore.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rapcore \
  -f tb.f -o sim_rapcore
./obj_dir/sim_rapcore | tee sim.log

if grep -qx "Test passed" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// ==== verif/tb_rapcore.sv ====
`timescale 1ns/1ns

module tb_rapcore;

  localparam int SPI_HALF = 6; // CLK cycles per SCK half period
  localparam int ENC_HOLD = 8;

  logic CLK;
  logic resetn;
  logic sck;
  logic cs;
  logic copi;
  logic cipo;
  logic enc_a;
  logic enc_b;
  logic step_out;
  logic dir_out;
  logic move_done;
  logic buffer_dtr;
  logic phase_a1;
  logic phase_a2;
  logic phase_b1;
  logic phase_b2;
  logic vref_a;
  logic vref_b;

  integer      seed;
  int          mismatches;
  int          other_errs;
  logic [47:0] rx;

  // Moves sent but not yet played out with the oldest first
  int   q_period[$];
  int   q_steps[$];
  logic q_dir[$];

  int   cyc;
  int   ref_cyc;
  int   last_pulse;
  int   left;
  int   cur_period;
  int   gap;
  int   total_pulses;
  int   exp_total;
  logic cur_dir;
  logic done_q;
  logic first;

  logic [7:0] angle_base;
  int         acc_steps;
  logic [2:0] cfg_us;
  logic       cfg_en;
  int         enc_count_exp;
  int         k;
  int         j;

  rapcore i_rapcore (
    .CLK(CLK), .resetn(resetn), .sck(sck), .cs(cs), .copi(copi), .cipo(cipo),
    .enc_a(enc_a), .enc_b(enc_b), .step_out(step_out), .dir_out(dir_out),
    .move_done(move_done), .buffer_dtr(buffer_dtr),
    .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1), .phase_b2(phase_b2),
    .vref_a(vref_a), .vref_b(vref_b)
  );

  always #5 CLK = ~CLK;

  // Angle and {a1, a2, b1, b2} from the steps taken since the last rebase
  function automatic logic [11:0] motor_ref(input logic [7:0] base, input int acc,
                                            input logic [2:0] us, input logic en);
    logic [7:0] angle;
    logic [3:0] pins;
    angle = base + 8'(acc * (64 >> us));
    case (angle[7:6])
      2'd0:    pins = 4'b1010;
      2'd1:    pins = 4'b0110;
      2'd2:    pins = 4'b0101;
      default: pins = 4'b1001;
    endcase
    return {angle, en ? pins : 4'b0000};
  endfunction

  function automatic logic [47:0] expected_status(input logic dtr, input logic done,
                                                  input int count);
    logic [47:0] status;
    status       = '0;
    status[33]   = dtr;
    status[32]   = done;
    status[31:0] = count;
    return status;
  endfunction

  task automatic check_eq(input logic [47:0] got, input logic [47:0] exp, input string what);
    assert (got === exp) else begin
      $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      mismatches++;
    end
  endtask

  task automatic tick(input int n);
    repeat (n) @(posedge CLK);
    #1;
  endtask

  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    while (!move_done && n < limit) begin
      tick(1);
      n++;
    end
    if (!move_done) begin
      $display("Timeout: move_done still low after %0d cycles", limit);
      other_errs++;
    end
  endtask

  task automatic wait_buffer_free(input int limit);
    int n;
    n = 0;
    while (!buffer_dtr && n < limit) begin
      tick(1);
      n++;
    end
    if (!buffer_dtr) begin
      $display("Timeout: move buffer did not empty within %0d cycles", limit);
      other_errs++;
    end
  endtask

  // Mode 0, MSB first; status sampled as SCK rises
  task automatic spi_frame(input logic [47:0] tx, output logic [47:0] status);
    cs = 1'b0;
    tick(SPI_HALF);
    for (int i = 47; i >= 0; i--) begin
      copi = tx[i];
      tick(SPI_HALF);
      sck       = 1'b1;
      status[i] = cipo;
      tick(SPI_HALF);
      sck = 1'b0;
    end
    tick(SPI_HALF);
    cs = 1'b1;
    tick(SPI_HALF);
  endtask

  task automatic read_status(input logic [47:0] exp);
    spi_frame(48'd0, rx);
    check_eq(rx, exp, "status word");
  endtask

  task automatic send_move(input int period, input int steps, input logic dir);
    q_period.push_back(period);
    q_steps.push_back(steps);
    q_dir.push_back(dir);
    acc_steps += dir ? steps : -steps;
    exp_total += steps;
    spi_frame({cmd_pkg::OP_MOVE, 7'd0, dir, 16'(steps), 16'(period)}, rx);
  endtask

  task automatic send_config(input logic [2:0] us, input logic [7:0] cur, input logic en);
    logic [11:0] now;
    now        = motor_ref(angle_base, acc_steps, cfg_us, cfg_en);
    angle_base = now[11:4]; // Step size changes from here on
    acc_steps  = 0;
    cfg_us     = us;
    cfg_en     = en;
    spi_frame({cmd_pkg::OP_CONFIG, 23'd0, en, cur, 5'd0, us}, rx);
  endtask

  task automatic check_phases();
    logic [11:0] exp;
    exp = motor_ref(angle_base, acc_steps, cfg_us, cfg_en);
    check_eq({phase_a1, phase_a2, phase_b1, phase_b2}, exp[3:0], "phase pins");
  endtask

  task automatic random_move();
    int steps;
    int period;
    steps  = 1 + ({$random(seed)} % 40);
    period = 2 + ({$random(seed)} % 19);
    send_move(period, steps, $random(seed) & 1);
    wait_idle(2000);
    check_eq(left, 0, "step pulses still owed");
    check_phases();
  endtask

  // Gray order 00, 10, 11, 01 going forward
  task automatic enc_step(input logic fwd);
    enc_count_exp = fwd ? enc_count_exp + 1 : enc_count_exp - 1;
    case (enc_count_exp & 3)
      0:       {enc_a, enc_b} = 2'b00;
      1:       {enc_a, enc_b} = 2'b10;
      2:       {enc_a, enc_b} = 2'b11;
      default: {enc_a, enc_b} = 2'b01;
    endcase
    tick(ENC_HOLD);
  endtask

  always @(negedge CLK) begin
    cyc = cyc + 1;
    if (!resetn) begin
      done_q = 1'b1;
      left   = 0;
    end else begin
      if (done_q && !move_done)
        ref_cyc = cyc; // Transfer cycle of a move from idle
      if (!done_q && move_done)
        check_eq(cyc - last_pulse, 1, "move_done rise after last pulse");
      done_q = move_done;
      if (step_out) begin
        total_pulses++;
        first = (left == 0);
        if (first && q_period.size() > 0) begin
          cur_period = q_period.pop_front();
          left       = q_steps.pop_front();
          cur_dir    = q_dir.pop_front();
        end
        if (left == 0) begin
          $display("Step pulse at %0t ns with no move pending", $time);
          other_errs++;
        end else begin
          gap = first ? cyc - ref_cyc : cyc - last_pulse;
          check_eq(gap, cur_period, "step pulse spacing");
          check_eq(dir_out, cur_dir, "dir_out");
          left--;
          if (left == 0)
            ref_cyc = cyc + 1; // A buffered move transfers next cycle
        end
        last_pulse = cyc;
      end
    end
  end

  initial begin
    CLK           = 1'b0;
    resetn        = 1'b0;
    sck           = 1'b0;
    cs            = 1'b1;
    copi          = 1'b0;
    enc_a         = 1'b0;
    enc_b         = 1'b0;
    seed          = 71;
    mismatches    = 0;
    other_errs    = 0;
    cyc           = 0;
    ref_cyc       = 0;
    last_pulse    = 0;
    left          = 0;
    total_pulses  = 0;
    exp_total     = 0;
    done_q        = 1'b1;
    angle_base    = 8'd0;
    acc_steps     = 0;
    cfg_us        = 3'd0;
    cfg_en        = 1'b0;
    enc_count_exp = 0;
    tick(4);
    resetn = 1'b1;
    tick(2);

    check_eq({move_done, buffer_dtr, step_out}, 3'b110, "flags after reset");
    check_eq({phase_a1, phase_a2, phase_b1, phase_b2, vref_a, vref_b}, 6'd0,
             "bridge pins after reset");
    read_status(expected_status(1'b1, 1'b1, 0));

    repeat (4) random_move(); // Bridge still disabled

    send_config({$random(seed)} % 7, 8'hc0, 1'b1);
    check_phases();
    repeat (5) random_move();
    send_config(cfg_us, 8'hc0, 1'b0);
    check_phases();
    check_eq({vref_a, vref_b}, 2'b00, "vref while disabled");
    send_config(cfg_us, 8'hc0, 1'b1);

    // Second move waits in the buffer behind a long first move
    send_move(100, 20, 1'b1);
    send_move(50, 20, 1'b0);
    read_status(expected_status(1'b0, 1'b0, enc_count_exp));
    wait_buffer_free(5000);
    send_move(2 + ({$random(seed)} % 19), 1 + ({$random(seed)} % 40), 1'b1);
    wait_idle(5000);
    check_eq(left, 0, "step pulses still owed");
    check_eq(total_pulses, exp_total, "total step pulses");
    check_phases();

    k = 3 + ({$random(seed)} % 12);
    j = {$random(seed)} % 16;
    repeat (k) enc_step(1'b1);
    repeat (j) enc_step(1'b0);
    spi_frame({8'hc3, 40'h00_0002_ff07}, rx); // Unknown opcode with a config-like payload
    check_eq(rx, expected_status(1'b1, 1'b1, k - j), "status after encoder moves");
    tick(20);
    check_eq({move_done, buffer_dtr}, 2'b11, "flags after unknown opcode");
    check_phases();
    random_move();
    check_eq(total_pulses, exp_total, "total step pulses");

    $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== src/rapcore.sv ====
`timescale 1ns/1ns

module rapcore (
  input  logic CLK,
  input  logic resetn,
  input  logic sck,
  input  logic cs,
  input  logic copi,
  output logic cipo,
  input  logic enc_a,
  input  logic enc_b,
  output logic step_out,
  output logic dir_out,
  output logic move_done,
  output logic buffer_dtr,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic vref_a,
  output logic vref_b
);

  motor_pkg::enc_count_t enc_count;
  motor_pkg::usteps_t    microsteps;
  motor_pkg::current_t   current;
  logic                  enable;
  logic                  frame_valid;
  logic                  frame_ready;
  cmd_pkg::frame_t       frame;

  move_if mv ();

  spi_target spi0 (
    .CLK(CLK), .resetn(resetn), .sck(sck), .cs(cs), .copi(copi), .cipo(cipo),
    .count(enc_count), .move_done(move_done), .buffer_dtr(buffer_dtr),
    .frame_valid(frame_valid), .frame(frame), .frame_ready(frame_ready)
  );

  cmd_fsm cmd0 (
    .CLK(CLK), .resetn(resetn),
    .frame_valid(frame_valid), .frame(frame), .frame_ready(frame_ready), .mv(mv),
    .microsteps(microsteps), .current(current), .enable(enable), .buffer_dtr(buffer_dtr)
  );

  step_timer timer0 (
    .CLK(CLK), .resetn(resetn), .mv(mv),
    .step_pulse(step_out), .dir(dir_out), .move_done(move_done)
  );

  dual_hbridge bridge0 (
    .CLK(CLK), .resetn(resetn), .step_pulse(step_out), .dir(dir_out),
    .enable(enable), .microsteps(microsteps), .current(current),
    .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1), .phase_b2(phase_b2),
    .vref_a(vref_a), .vref_b(vref_b)
  );

  quad_enc enc0 (
    .CLK(CLK), .resetn(resetn), .a(enc_a), .b(enc_b), .count(enc_count)
  );

endmodule

// ==== src/quad_enc.sv ====
`timescale 1ns/1ns

module quad_enc (
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic                  a,
  input  logic                  b,
  output motor_pkg::enc_count_t count
);

  logic [2:0] a_q;
  logic [2:0] b_q; // Two sync stages plus the previous sample
  logic       a_chg;
  logic       b_chg;
  logic       fwd;

  assign a_chg = a_q[1] ^ a_q[2];
  assign b_chg = b_q[1] ^ b_q[2];
  assign fwd   = a_q[1] ^ b_q[2]; // a leads b

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      a_q   <= '0;
      b_q   <= '0;
      count <= '0;
    end else begin
      a_q <= {a_q[1:0], a};
      b_q <= {b_q[1:0], b};
      if (a_chg ^ b_chg) begin
        if (fwd)
          count <= count + 1'b1;
        else
          count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== src/dual_hbridge.sv ====
`timescale 1ns/1ns

module dual_hbridge (
  input  logic                CLK,
  input  logic                resetn,
  input  logic                step_pulse,
  input  logic                dir,
  input  logic                enable,
  input  motor_pkg::usteps_t  microsteps,
  input  motor_pkg::current_t current,
  output logic                phase_a1,
  output logic                phase_a2,
  output logic                phase_b1,
  output logic                phase_b2,
  output logic                vref_a,
  output logic                vref_b
);

  motor_pkg::angle_t angle;
  motor_pkg::angle_t angle_inc;
  logic [1:0]        quad;
  logic [3:0]        frac;
  logic [3:0]        idx_a;
  logic [3:0]        idx_b;
  logic [7:0]        pwm_cnt;
  logic [15:0]       scaled_a;
  logic [15:0]       scaled_b;

  assign angle_inc = motor_pkg::angle_t'(motor_pkg::FULL_STEP_ANGLE) >> microsteps;
  assign quad      = angle[7:6];
  assign frac      = angle[5:2];

  assign phase_a1 = enable & ~^quad; // Quadrants 0 and 3
  assign phase_a2 = enable & ^quad;
  assign phase_b1 = enable & ~quad[1];
  assign phase_b2 = enable & quad[1];

  // Cosine magnitude for a, sine for b, mirrored in odd quadrants
  assign idx_a    = quad[0] ? frac : ~frac;
  assign idx_b    = quad[0] ? ~frac : frac;
  assign scaled_a = current * motor_pkg::SIN_QUARTER[idx_a];
  assign scaled_b = current * motor_pkg::SIN_QUARTER[idx_b];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      angle   <= '0;
      pwm_cnt <= '0;
      vref_a  <= 1'b0;
      vref_b  <= 1'b0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
      vref_a  <= enable && (pwm_cnt < scaled_a[15:8]);
      vref_b  <= enable && (pwm_cnt < scaled_b[15:8]);
      if (step_pulse)
        angle <= dir ? angle + angle_inc : angle - angle_inc;
    end
  end

endmodule

// ==== src/step_timer.sv ====
`timescale 1ns/1ns

module step_timer (
  input  logic CLK,
  input  logic resetn,
  move_if.timer mv,
  output logic step_pulse,
  output logic dir,
  output logic move_done
);

  logic               busy;
  logic               start;
  motor_pkg::period_t period_q;
  motor_pkg::period_t period_cnt;
  motor_pkg::steps_t  steps_left;

  assign mv.ready  = ~busy;
  assign start     = mv.valid && mv.ready;
  assign move_done = ~(busy || mv.valid); // Low already in the transfer cycle

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      busy       <= 1'b0;
      step_pulse <= 1'b0;
      dir        <= 1'b0;
    end else begin
      step_pulse <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        dir  <= mv.dir;
      end else if (busy) begin
        if (steps_left == '0)
          busy <= 1'b0;
        else if (period_cnt == 16'd1)
          step_pulse <= 1'b1;
      end
    end
  end

  // First reload is one short so the first pulse lands period cycles out
  always_ff @(posedge CLK) begin
    if (start) begin
      period_q   <= mv.period;
      period_cnt <= mv.period - 1'b1;
      steps_left <= mv.steps;
    end else if (busy && steps_left != '0) begin
      if (period_cnt == 16'd1) begin
        period_cnt <= period_q;
        steps_left <= steps_left - 1'b1;
      end else begin
        period_cnt <= period_cnt - 1'b1;
      end
    end
  end

  assert property (@(posedge CLK) disable iff (!resetn) step_pulse |=> !step_pulse);

endmodule

// ==== src/cmd_fsm.sv ====
`timescale 1ns/1ns

module cmd_fsm (
  input  logic                CLK,
  input  logic                resetn,
  input  logic                frame_valid,
  input  cmd_pkg::frame_t     frame,
  output logic                frame_ready,
  move_if.ctrl                mv,
  output motor_pkg::usteps_t  microsteps,
  output motor_pkg::current_t current,
  output logic                enable,
  output logic                buffer_dtr
);

  cmd_pkg::cmd_state_t state;
  cmd_pkg::frame_t     cmd_q;
  cmd_pkg::opcode_t    op;
  logic                xfer;
  logic                pend; // Frame taken while the last one was decoded

  assign xfer        = frame_valid && frame_ready;
  assign frame_ready = (state != cmd_pkg::HOLD);
  assign op          = cmd_q[cmd_pkg::FRAME_BITS-1 -: cmd_pkg::OP_BITS];
  assign buffer_dtr  = ~mv.valid;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state      <= cmd_pkg::IDLE;
      pend       <= 1'b0;
      mv.valid   <= 1'b0;
      microsteps <= '0;
      current    <= '0;
      enable     <= 1'b0;
    end else begin
      case (state)
        cmd_pkg::IDLE: begin
          if (xfer)
            state <= cmd_pkg::DECODE;
        end
        cmd_pkg::DECODE: begin
          pend <= xfer;
          if (op == cmd_pkg::OP_CONFIG) begin
            microsteps <= cmd_q[2:0];
            current    <= cmd_q[15:8];
            enable     <= cmd_q[16];
          end
          if (op == cmd_pkg::OP_MOVE) begin
            mv.valid <= 1'b1; // Slot is always empty here
            state    <= cmd_pkg::HOLD;
          end else if (!xfer) begin
            state <= cmd_pkg::IDLE;
          end
        end
        cmd_pkg::HOLD: begin
          if (mv.ready) begin
            mv.valid <= 1'b0;
            state    <= pend ? cmd_pkg::DECODE : cmd_pkg::IDLE;
          end
        end
        default: state <= cmd_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (xfer)
      cmd_q <= frame;
    if (state == cmd_pkg::DECODE && op == cmd_pkg::OP_MOVE) begin
      mv.period <= cmd_q[15:0];
      mv.steps  <= cmd_q[31:16];
      mv.dir    <= cmd_q[32];
    end
  end

  assert property (@(posedge CLK) disable iff (!resetn)
    mv.valid && !mv.ready |=> mv.valid && $stable({mv.dir, mv.steps, mv.period}));

endmodule

// ==== src/spi_target.sv ====
`timescale 1ns/1ns

module spi_target (
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic                  sck,
  input  logic                  cs,
  input  logic                  copi,
  output logic                  cipo,
  input  motor_pkg::enc_count_t count,
  input  logic                  move_done,
  input  logic                  buffer_dtr,
  output logic                  frame_valid,
  output cmd_pkg::frame_t       frame,
  input  logic                  frame_ready
);

  logic [2:0]      sck_q;
  logic [2:0]      cs_q;
  logic [1:0]      copi_q;
  logic            sck_rise;
  logic            sck_fall;
  logic            cs_fall;
  logic            cs_rise;
  logic            cs_active;
  logic            frame_end;
  logic            frame_load;
  logic [5:0]      bit_cnt;
  cmd_pkg::frame_t rx_sr;
  cmd_pkg::frame_t tx_sr;

  assign sck_rise  = sck_q[1] & ~sck_q[2];
  assign sck_fall  = ~sck_q[1] & sck_q[2];
  assign cs_fall   = ~cs_q[1] & cs_q[2];
  assign cs_rise   = cs_q[1] & ~cs_q[2];
  assign cs_active = ~cs_q[1];
  assign frame_end = cs_active && sck_rise && (bit_cnt == 6'(cmd_pkg::FRAME_BITS - 1));
  assign frame_load = frame_end && (!frame_valid || frame_ready); // Else dropped
  assign cipo = tx_sr[cmd_pkg::FRAME_BITS-1];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_q       <= '0;
      cs_q        <= '1;
      copi_q      <= '0;
      bit_cnt     <= '0;
      tx_sr       <= '0;
      frame_valid <= 1'b0;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      cs_q   <= {cs_q[1:0], cs};
      copi_q <= {copi_q[0], copi};
      if (cs_fall) begin
        bit_cnt <= '0;
        tx_sr   <= {14'd0, buffer_dtr, move_done, count};
      end else if (cs_rise) begin
        bit_cnt <= '0; // Short frame thrown away
      end else if (cs_active) begin
        if (sck_rise)
          bit_cnt <= frame_end ? '0 : bit_cnt + 1'b1;
        if (sck_fall)
          tx_sr <= {tx_sr[cmd_pkg::FRAME_BITS-2:0], 1'b0};
      end
      if (frame_valid && frame_ready)
        frame_valid <= 1'b0;
      if (frame_load)
        frame_valid <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (cs_active && sck_rise)
      rx_sr <= {rx_sr[cmd_pkg::FRAME_BITS-2:0], copi_q[1]};
    if (frame_load)
      frame <= {rx_sr[cmd_pkg::FRAME_BITS-2:0], copi_q[1]};
  end

  assert property (@(posedge CLK) disable iff (!resetn)
    frame_valid && !frame_ready |=> frame_valid && $stable(frame));

endmodule

// ==== src/move_if.sv ====
`timescale 1ns/1ns

interface move_if;

  logic               valid;
  logic               ready;
  logic               dir;
  motor_pkg::steps_t  steps;
  motor_pkg::period_t period;

  modport ctrl (
    output valid, dir, steps, period,
    input  ready
  );

  modport timer (
    input  valid, dir, steps, period,
    output ready
  );

endinterface

// ==== src/cmd_pkg.sv ====
package cmd_pkg;

  localparam int FRAME_BITS = 48;
  localparam int OP_BITS    = 8;

  // Opcode in the top byte, payload below
  typedef logic [FRAME_BITS-1:0] frame_t;
  typedef logic [OP_BITS-1:0]    opcode_t;

  localparam opcode_t OP_CONFIG = 8'h01;
  localparam opcode_t OP_MOVE   = 8'h02;

  typedef enum logic [1:0] {
    IDLE,
    DECODE,
    HOLD
  } cmd_state_t;

endpackage

// ==== src/motor_pkg.sv ====
package motor_pkg;

  localparam int ANGLE_BITS   = 8;
  localparam int USTEP_BITS   = 3;
  localparam int CURRENT_BITS = 8;
  localparam int STEPS_BITS   = 16;
  localparam int PERIOD_BITS  = 16;
  localparam int ENC_BITS     = 32;

  localparam int FULL_STEP_ANGLE = 64; // Quarter of an electrical period

  typedef logic [ANGLE_BITS-1:0]        angle_t;
  typedef logic [USTEP_BITS-1:0]        usteps_t;
  typedef logic [CURRENT_BITS-1:0]      current_t;
  typedef logic [STEPS_BITS-1:0]        steps_t;
  typedef logic [PERIOD_BITS-1:0]       period_t;
  typedef logic signed [ENC_BITS-1:0]   enc_count_t;

  // 255 * sin(i * 90 / 16 degrees)
  localparam logic [7:0] SIN_QUARTER [16] = '{
    8'd0,   8'd25,  8'd50,  8'd74,  8'd98,  8'd120, 8'd142, 8'd162,
    8'd180, 8'd197, 8'd212, 8'd225, 8'd236, 8'd244, 8'd250, 8'd254
  };

endpackage
